// File: verilog/gpu_macros.svh
/*
 * global sizing constants for the compute subsystem
 * address and data widths, memory depth and core port delay
 */
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// byte address and data word widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// global memory depth in words
`define MEM_WORDS 1024

// cycles from a core request to its ack, must be at least 2
`define MEM_DELAY 4

`endif

// File: verilog/mem_pkg.sv
/*
 * memory-side types: byte address, data word, word index
 */
`include "gpu_macros.svh"

package mem_pkg;

    // byte address as seen by host and core
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // one data word of global memory
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // word index into the array
    // taken from the byte address with the two low bits dropped
    typedef logic [$clog2(`MEM_WORDS)-1:0] index_t;

endpackage

// File: verilog/gpu_pkg.sv
/*
 * kernel-side definitions: element operations, sequencer states
 * and the host register map
 */
package gpu_pkg;

    // element operation, unknown codes act as a copy
    typedef enum logic [2:0] {
        OP_COPY = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_XOR  = 3'd4,
        OP_MAX  = 3'd5
    } op_e;

    // kernel sequencer FSM states
    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT_RD,
        WRITE,
        WAIT_WR,
        NEXT
    } seq_state_e;

    // register offsets, low byte of the Wishbone address
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_SRC    = 8'h04;
    localparam logic [7:0] REG_DST    = 8'h08;
    localparam logic [7:0] REG_COUNT  = 8'h0C;
    localparam logic [7:0] REG_SCALAR = 8'h10;
    localparam logic [7:0] REG_OP     = 8'h14;

    // Wishbone address bit that selects the memory window
    localparam int WIN_BIT = 15;

endpackage

// File: verilog/mem_core_if.sv
/*
 * core request bundle between the kernel sequencer and global memory
 */
`timescale 1ns/1ps

interface mem_core_if;

    // request side, one-cycle pulses with addr and wr_data alongside
    logic           rd_req;
    logic           wr_req;
    mem_pkg::addr_t addr;
    mem_pkg::data_t wr_data;

    // response side
    // rd_data is only nonzero in the ack cycle of a read
    mem_pkg::data_t rd_data;
    logic           busy;
    logic           ack;

    modport core (output rd_req, wr_req, addr, wr_data, input rd_data, busy, ack);
    modport mem  (input rd_req, wr_req, addr, wr_data, output rd_data, busy, ack);

endinterface

// File: verilog/global_mem_delayed.sv
/*
 * global memory array
 * delayed core port (request, busy, ack) and immediate host port
 */
`timescale 1ns/1ps
`include "gpu_macros.svh"

module global_mem_delayed (
    input  logic           clk,
    input  logic           rst,
    mem_core_if.mem        core,
    input  logic           host_wr_en,
    input  logic           host_rd_en,
    input  mem_pkg::addr_t host_addr,
    input  mem_pkg::data_t host_wr_data,
    output mem_pkg::data_t host_rd_data,
    output logic           host_rd_ack
);

    localparam int IDX_W = $bits(mem_pkg::index_t);
    // countdown only needs to reach MEM_DELAY-1
    localparam int CNT_W = $clog2(`MEM_DELAY);

    mem_pkg::data_t   mem_array [`MEM_WORDS];

    // the single latched core request
    logic             pend_rd;
    logic             pend_wr;
    mem_pkg::addr_t   pend_addr;
    mem_pkg::data_t   pend_data;
    logic [CNT_W-1:0] wait_cnt;

    logic             pending;
    logic             take_req;
    logic             fire;
    mem_pkg::index_t  pend_idx;
    mem_pkg::index_t  host_idx;

    assign pend_idx = pend_addr[IDX_W+1:2];
    assign host_idx = host_addr[IDX_W+1:2];
    assign pending  = pend_rd || pend_wr;
    assign take_req = !pending && (core.rd_req || core.wr_req);
    // last waiting cycle, so ack lands MEM_DELAY cycles after the request
    assign fire     = pending && (wait_cnt == CNT_W'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pend_rd      <= 1'b0;
            pend_wr      <= 1'b0;
            wait_cnt     <= '0;
            core.busy    <= 1'b0;
            core.ack     <= 1'b0;
            core.rd_data <= '0;
            host_rd_ack  <= 1'b0;
        end else begin
            core.ack     <= fire;
            // read data is zero outside the ack cycle
            core.rd_data <= '0;
            host_rd_ack  <= host_rd_en;
            if (fire) begin
                pend_rd   <= 1'b0;
                pend_wr   <= 1'b0;
                core.busy <= 1'b0;
                if (pend_rd) begin
                    core.rd_data <= mem_array[pend_idx];
                end
            end else if (pending) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else if (take_req) begin
                pend_rd   <= core.rd_req;
                pend_wr   <= core.wr_req;
                wait_cnt  <= CNT_W'(`MEM_DELAY - 1);
                core.busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            pend_addr <= core.addr;
            pend_data <= core.wr_data;
        end
        // host port goes straight to the array
        if (host_wr_en) begin
            mem_array[host_idx] <= host_wr_data;
        end
        // delayed core write lands together with its ack
        if (fire && pend_wr) begin
            mem_array[pend_idx] <= pend_data;
        end
        if (host_rd_en) begin
            host_rd_data <= mem_array[host_idx];
        end
    end

    // requester must wait out busy
    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst)
        core.busy |-> !(core.rd_req || core.wr_req));

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst)
        !(core.rd_req && core.wr_req));

endmodule

// File: verilog/host_wb_bridge.sv
/*
 * Wishbone classic slave with the kernel registers
 * and the host memory window, stalled while a kernel runs
 */
`timescale 1ns/1ps

module host_wb_bridge (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  mem_pkg::addr_t wb_adr,
    input  mem_pkg::data_t wb_dat_w,
    output mem_pkg::data_t wb_dat_r,
    output logic           wb_ack,
    input  logic           seq_busy,
    input  logic           seq_done,
    output logic           start,
    output mem_pkg::addr_t src,
    output mem_pkg::addr_t dst,
    output mem_pkg::data_t count,
    output mem_pkg::data_t scalar,
    output gpu_pkg::op_e   op,
    output logic           host_wr_en,
    output logic           host_rd_en,
    output mem_pkg::addr_t host_addr,
    output mem_pkg::data_t host_wr_data,
    input  mem_pkg::data_t host_rd_data,
    input  logic           host_rd_ack
);

    logic           win;
    logic           accept;
    logic           ack_q;
    logic           rd_pending;
    logic [7:0]     reg_off;
    mem_pkg::data_t reg_rdata;
    mem_pkg::data_t rdata_q;

    assign win     = wb_adr[gpu_pkg::WIN_BIT];
    assign reg_off = wb_adr[7:0];
    // no new transfer in the ack cycle, window held off while busy
    assign accept  = wb_cyc && wb_stb && !wb_ack && !rd_pending && !(win && seq_busy);

    // window reads are acked by the memory's read ack
    assign wb_ack   = ack_q || host_rd_ack;
    assign wb_dat_r = host_rd_ack ? host_rd_data : rdata_q;

    always_comb begin
        case (reg_off)
            gpu_pkg::REG_CTRL:   reg_rdata = {30'd0, seq_done, seq_busy};
            gpu_pkg::REG_SRC:    reg_rdata = src;
            gpu_pkg::REG_DST:    reg_rdata = dst;
            gpu_pkg::REG_COUNT:  reg_rdata = count;
            gpu_pkg::REG_SCALAR: reg_rdata = scalar;
            gpu_pkg::REG_OP:     reg_rdata = mem_pkg::data_t'(op);
            default:             reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_q      <= 1'b0;
            start      <= 1'b0;
            host_wr_en <= 1'b0;
            host_rd_en <= 1'b0;
            rd_pending <= 1'b0;
            src        <= '0;
            dst        <= '0;
            count      <= '0;
            scalar     <= '0;
            op         <= gpu_pkg::OP_COPY;
        end else begin
            ack_q      <= 1'b0;
            start      <= 1'b0;
            host_wr_en <= 1'b0;
            host_rd_en <= 1'b0;
            if (host_rd_ack) begin
                rd_pending <= 1'b0;
            end
            if (accept && win) begin
                // window write acks at once, read waits two cycles
                host_wr_en <= wb_we;
                host_rd_en <= !wb_we;
                rd_pending <= !wb_we;
                ack_q      <= wb_we;
            end else if (accept) begin
                ack_q <= 1'b1;
                if (wb_we) begin
                    case (reg_off)
                        gpu_pkg::REG_CTRL:   start  <= wb_dat_w[0];
                        gpu_pkg::REG_SRC:    src    <= wb_dat_w;
                        gpu_pkg::REG_DST:    dst    <= wb_dat_w;
                        gpu_pkg::REG_COUNT:  count  <= wb_dat_w;
                        gpu_pkg::REG_SCALAR: scalar <= wb_dat_w;
                        gpu_pkg::REG_OP:     op     <= gpu_pkg::op_e'(wb_dat_w[2:0]);
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q      <= reg_rdata;
            host_addr    <= wb_adr;
            host_wr_data <= wb_dat_w;
        end
    end

    // ack only inside a live master cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: verilog/lane_alu.sv
/*
 * single lane element operation on a word and the kernel scalar
 */
`timescale 1ns/1ps

module lane_alu (
    input  gpu_pkg::op_e   op,
    input  mem_pkg::data_t operand,
    input  mem_pkg::data_t scalar,
    output mem_pkg::data_t result
);

    mem_pkg::data_t product;

    // only the low word of the product is kept
    assign product = operand * scalar;

    always_comb begin
        case (op)
            gpu_pkg::OP_ADD: result = operand + scalar;
            gpu_pkg::OP_SUB: result = operand - scalar;
            gpu_pkg::OP_MUL: result = product;
            gpu_pkg::OP_XOR: result = operand ^ scalar;
            // unsigned compare
            gpu_pkg::OP_MAX: result = (operand > scalar) ? operand : scalar;
            // copy and unused codes pass the word through
            default:         result = operand;
        endcase
    end

endmodule

// File: verilog/kernel_sequencer.sv
/*
 * kernel control FSM
 * per element: read source, compute in the lane ALU, write destination
 */
`timescale 1ns/1ps

module kernel_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  mem_pkg::addr_t src,
    input  mem_pkg::addr_t dst,
    input  mem_pkg::data_t count,
    input  mem_pkg::data_t scalar,
    input  gpu_pkg::op_e   op,
    output logic           busy,
    output logic           done,
    mem_core_if.core       core,
    output mem_pkg::data_t alu_operand,
    output gpu_pkg::op_e   alu_op,
    output mem_pkg::data_t alu_scalar,
    input  mem_pkg::data_t alu_result
);

    gpu_pkg::seq_state_e state;
    mem_pkg::data_t      remaining;
    mem_pkg::addr_t      rd_addr;
    mem_pkg::addr_t      wr_addr;
    mem_pkg::data_t      scalar_q;
    mem_pkg::data_t      result_q;
    gpu_pkg::op_e        op_q;
    logic                launch;
    logic                wr_done;

    assign launch  = (state == gpu_pkg::IDLE) && start;
    assign wr_done = (state == gpu_pkg::WAIT_WR) && core.ack;

    // requests are single pulses, issued once memory is free
    assign core.rd_req  = (state == gpu_pkg::READ) && !core.busy;
    assign core.wr_req  = (state == gpu_pkg::WRITE) && !core.busy;
    assign core.addr    = (state == gpu_pkg::WRITE) ? wr_addr : rd_addr;
    assign core.wr_data = result_q;

    // read data is valid in the ack cycle, when it is registered
    assign alu_operand = core.rd_data;
    assign alu_op      = op_q;
    assign alu_scalar  = scalar_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= gpu_pkg::IDLE;
            remaining <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                gpu_pkg::IDLE: begin
                    if (start) begin
                        remaining <= count;
                        busy      <= 1'b1;
                        done      <= 1'b0;
                        state     <= gpu_pkg::NEXT;
                    end
                end
                gpu_pkg::READ:    if (!core.busy) state <= gpu_pkg::WAIT_RD;
                gpu_pkg::WAIT_RD: if (core.ack) state <= gpu_pkg::WRITE;
                gpu_pkg::WRITE:   if (!core.busy) state <= gpu_pkg::WAIT_WR;
                gpu_pkg::WAIT_WR: begin
                    if (core.ack) begin
                        remaining <= remaining - 1'b1;
                        state     <= gpu_pkg::NEXT;
                    end
                end
                gpu_pkg::NEXT: begin
                    // zero count finishes here right after start
                    if (remaining == '0) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= gpu_pkg::IDLE;
                    end else begin
                        state <= gpu_pkg::READ;
                    end
                end
                default: state <= gpu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            rd_addr  <= src;
            wr_addr  <= dst;
            scalar_q <= scalar;
            op_q     <= op;
        end else if (wr_done) begin
            // next word
            rd_addr <= rd_addr + 32'd4;
            wr_addr <= wr_addr + 32'd4;
        end
        if ((state == gpu_pkg::WAIT_RD) && core.ack) begin
            result_q <= alu_result;
        end
    end

    // one request in flight, the next waits for the ack
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst)
        (core.rd_req || core.wr_req) |=> !(core.rd_req || core.wr_req) until core.ack);

endmodule

// File: verilog/gpu_top.sv
/*
 * compute subsystem top: bridge, sequencer, lane ALU, global memory
 */
`timescale 1ns/1ps

module gpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  mem_pkg::addr_t wb_adr,
    input  mem_pkg::data_t wb_dat_w,
    output mem_pkg::data_t wb_dat_r,
    output logic           wb_ack,
    output logic           done
);

    // bridge to sequencer
    logic           start;
    logic           seq_busy;
    mem_pkg::addr_t src;
    mem_pkg::addr_t dst;
    mem_pkg::data_t count;
    mem_pkg::data_t scalar;
    gpu_pkg::op_e   op;

    // bridge to memory host port
    logic           host_wr_en;
    logic           host_rd_en;
    logic           host_rd_ack;
    mem_pkg::addr_t host_addr;
    mem_pkg::data_t host_wr_data;
    mem_pkg::data_t host_rd_data;

    // sequencer to lane ALU
    mem_pkg::data_t alu_operand;
    mem_pkg::data_t alu_scalar;
    mem_pkg::data_t alu_result;
    gpu_pkg::op_e   alu_op;

    mem_core_if core_bus ();

    host_wb_bridge u_bridge (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .seq_busy     (seq_busy),
        .seq_done     (done),
        .start        (start),
        .src          (src),
        .dst          (dst),
        .count        (count),
        .scalar       (scalar),
        .op           (op),
        .host_wr_en   (host_wr_en),
        .host_rd_en   (host_rd_en),
        .host_addr    (host_addr),
        .host_wr_data (host_wr_data),
        .host_rd_data (host_rd_data),
        .host_rd_ack  (host_rd_ack)
    );

    kernel_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .src         (src),
        .dst         (dst),
        .count       (count),
        .scalar      (scalar),
        .op          (op),
        .busy        (seq_busy),
        .done        (done),
        .core        (core_bus.core),
        .alu_operand (alu_operand),
        .alu_op      (alu_op),
        .alu_scalar  (alu_scalar),
        .alu_result  (alu_result)
    );

    lane_alu u_alu (
        .op      (alu_op),
        .operand (alu_operand),
        .scalar  (alu_scalar),
        .result  (alu_result)
    );

    global_mem_delayed u_mem (
        .clk          (clk),
        .rst          (rst),
        .core         (core_bus.mem),
        .host_wr_en   (host_wr_en),
        .host_rd_en   (host_rd_en),
        .host_addr    (host_addr),
        .host_wr_data (host_wr_data),
        .host_rd_data (host_rd_data),
        .host_rd_ack  (host_rd_ack)
    );

endmodule

// File: tb/tb_gpu_top.sv
/*
 * compute subsystem testbench with Wishbone host tasks and LCG data
 * memory model, reference element function and checking process
 */
`timescale 1ns/1ps
`include "gpu_macros.svh"

module tb_gpu_top;

    localparam int ACK_TIMEOUT  = 2000;
    localparam int DONE_TIMEOUT = 4000;
    // address bit 15 opens the memory window
    localparam mem_pkg::addr_t WIN_BASE = 32'h0000_8000;

    logic           clk;
    logic           rst;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    mem_pkg::addr_t wb_adr;
    mem_pkg::data_t wb_dat_w;
    mem_pkg::data_t wb_dat_r;
    logic           wb_ack;
    logic           done;

    logic [31:0]    lcg_state;
    // expected contents of every word written so far
    mem_pkg::data_t model [`MEM_WORDS];

    // pending comparisons for the checking process
    string          name_q [$];
    mem_pkg::data_t exp_q [$];
    mem_pkg::data_t act_q [$];
    event           check_ev;

    gpu_top dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .done     (done)
    );

    // 20 ns period
    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // element result as the operation table defines it
    function automatic mem_pkg::data_t expected_element(input logic [2:0] op,
                                                        input mem_pkg::data_t in,
                                                        input mem_pkg::data_t scalar);
        logic [63:0] prod;
        prod = {32'd0, in} * {32'd0, scalar};
        case (op)
            gpu_pkg::OP_ADD: return in + scalar;
            gpu_pkg::OP_SUB: return in - scalar;
            gpu_pkg::OP_MUL: return prod[31:0];
            gpu_pkg::OP_XOR: return in ^ scalar;
            gpu_pkg::OP_MAX: return (in > scalar) ? in : scalar;
            // copy and unused codes
            default:         return in;
        endcase
    endfunction

    function automatic mem_pkg::addr_t win_addr(input int idx);
        return WIN_BASE | mem_pkg::addr_t'(idx << 2);
    endfunction

    function automatic mem_pkg::addr_t reg_addr(input logic [7:0] off);
        return {24'd0, off};
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic post_check(input string name, input mem_pkg::data_t exp,
                              input mem_pkg::data_t act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        -> check_ev;
    endtask

    // drains every queued comparison in posting order
    always @(check_ev) begin
        string          name;
        mem_pkg::data_t exp;
        mem_pkg::data_t act;
        while (act_q.size() > 0) begin
            name = name_q.pop_front();
            exp  = exp_q.pop_front();
            act  = act_q.pop_front();
            assert (act === exp) else
                stop_on_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    end

    // classic write with ack sampled mid cycle
    task automatic wb_write(input mem_pkg::addr_t adr, input mem_pkg::data_t dat);
        int waited;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_on_failure($sformatf("no Wishbone ack for the write to %h", adr));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input mem_pkg::addr_t adr, output mem_pkg::data_t dat);
        int waited;
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_on_failure($sformatf("no Wishbone ack for the read from %h", adr));
            end
            @(negedge clk);
        end
        dat = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done) begin
            waited++;
            if (waited > DONE_TIMEOUT) begin
                stop_on_failure("kernel never raised done");
            end
            @(negedge clk);
        end
    endtask

    task automatic write_word(input int idx, input mem_pkg::data_t val);
        wb_write(win_addr(idx), val);
        model[idx] = val;
    endtask

    task automatic check_word(input string name, input int idx);
        mem_pkg::data_t rd;
        wb_read(win_addr(idx), rd);
        post_check($sformatf("%s word %0d", name, idx), model[idx], rd);
    endtask

    task automatic program_kernel(input int src_idx, input int dst_idx, input int n,
                                  input mem_pkg::data_t scalar, input logic [2:0] op);
        wb_write(reg_addr(gpu_pkg::REG_SRC), mem_pkg::addr_t'(src_idx << 2));
        wb_write(reg_addr(gpu_pkg::REG_DST), mem_pkg::addr_t'(dst_idx << 2));
        wb_write(reg_addr(gpu_pkg::REG_COUNT), mem_pkg::data_t'(n));
        wb_write(reg_addr(gpu_pkg::REG_SCALAR), scalar);
        wb_write(reg_addr(gpu_pkg::REG_OP), {29'd0, op});
    endtask

    // elements are applied in order so in place kernels match too
    task automatic apply_kernel_model(input int src_idx, input int dst_idx, input int n,
                                      input mem_pkg::data_t scalar, input logic [2:0] op);
        for (int i = 0; i < n; i++) begin
            model[dst_idx + i] = expected_element(op, model[src_idx + i], scalar);
        end
    endtask

    task automatic run_kernel(input string name, input int src_idx, input int dst_idx,
                              input int n, input logic [2:0] op);
        mem_pkg::data_t scalar;
        scalar = next_random();
        for (int i = 0; i < 16; i++) begin
            write_word(src_idx + i, next_random());
        end
        program_kernel(src_idx, dst_idx, n, scalar, op);
        apply_kernel_model(src_idx, dst_idx, n, scalar, op);
        wb_write(reg_addr(gpu_pkg::REG_CTRL), 32'd1);
        wait_done();
        for (int i = 0; i < 16; i++) begin
            check_word({name, " dst"}, dst_idx + i);
            check_word({name, " src"}, src_idx + i);
        end
    endtask

    initial begin
        mem_pkg::data_t rd;
        mem_pkg::data_t val;
        logic [7:0]     offs [5];
        int             idx_list [20];

        clk         = 1'b0;
        rst         = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        lcg_state   = 32'd60;
        offs        = '{gpu_pkg::REG_SRC, gpu_pkg::REG_DST, gpu_pkg::REG_COUNT,
                        gpu_pkg::REG_SCALAR, gpu_pkg::REG_OP};

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b1;

        // idle state after reset
        @(negedge clk);
        post_check("done after reset", 32'd0, {31'd0, done});
        wb_read(reg_addr(gpu_pkg::REG_CTRL), rd);
        post_check("ctrl after reset", 32'd0, rd);

        // kernel register readback where op keeps only three bits
        foreach (offs[k]) begin
            val = next_random();
            wb_write(reg_addr(offs[k]), val);
            wb_read(reg_addr(offs[k]), rd);
            if (offs[k] == gpu_pkg::REG_OP) begin
                post_check("reg op", {29'd0, val[2:0]}, {29'd0, rd[2:0]});
            end else begin
                post_check($sformatf("reg %h", offs[k]), val, rd);
            end
        end

        // window writes at random words in the low region
        for (int i = 0; i < 20; i++) begin
            val         = next_random();
            idx_list[i] = int'((val >> 8) % 256);
            write_word(idx_list[i], next_random());
        end
        for (int i = 0; i < 20; i++) begin
            check_word("window", idx_list[i]);
        end

        // every operation plus one unused code
        for (int k = 0; k < 7; k++) begin
            run_kernel($sformatf("op %0d", k), 512, 768, 16, k[2:0]);
        end

        run_kernel("in place", 600, 600, 16, gpu_pkg::OP_MUL);

        // zero count must leave the destination alone
        for (int i = 0; i < 16; i++) begin
            write_word(800 + i, next_random());
        end
        run_kernel("count zero", 700, 800, 0, gpu_pkg::OP_ADD);

        // window read held off while the kernel runs
        for (int i = 0; i < 16; i++) begin
            write_word(512 + i, next_random());
        end
        val = next_random();
        program_kernel(512, 768, 16, val, gpu_pkg::OP_ADD);
        apply_kernel_model(512, 768, 16, val, gpu_pkg::OP_ADD);
        wb_write(reg_addr(gpu_pkg::REG_CTRL), 32'd1);
        wb_read(win_addr(768 + 15), rd);
        post_check("done at held read", 32'd1, {31'd0, done});
        post_check("held read", model[768 + 15], rd);
        wait_done();
        for (int i = 0; i < 16; i++) begin
            check_word("after held read", 768 + i);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/gpu_pkg.sv
verilog/mem_core_if.sv
verilog/global_mem_delayed.sv
verilog/host_wb_bridge.sv
verilog/lane_alu.sv
verilog/kernel_sequencer.sv
verilog/gpu_top.sv
tb/tb_gpu_top.sv

// File: Bender.yml
package:
  name: gpu_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/gpu_pkg.sv
      - verilog/mem_core_if.sv
      - verilog/global_mem_delayed.sv
      - verilog/host_wb_bridge.sv
      - verilog/lane_alu.sv
      - verilog/kernel_sequencer.sv
      - verilog/gpu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_gpu_top.sv
